//--- vrc6.f
+incdir+include
verilog/vrc6_map_pkg.sv
verilog/vrc6_snd_pkg.sv
verilog/vrc6_pulse.sv
verilog/vrc6_saw.sv
verilog/vrc6_sound.sv
verilog/vrc6_irq.sv
verilog/vrc6_cpu_regs.sv
verilog/vrc6_mapper.sv
sim/vrc6_tb.sv

//--- include/vrc6_tb_ref.svh
// VRC6 testbench reference model
// expected bank translation, memory enables, IRQ delay, pulse duty and sawtooth levels,
// and the Galois LFSR behind the random stimulus
`ifndef VRC6_TB_REF_SVH
`define VRC6_TB_REF_SVH

// one Galois step, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// n fresh bits, one LFSR step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
endfunction

// CPU address of register idx, mapper 26 boards cross A0 and A1
function automatic logic [15:0] reg_addr(input logic [15:0] base, input logic [1:0] idx,
                                         input logic m26);
    return m26 ? {base[15:2], idx[0], idx[1]} : {base[15:2], idx};
endfunction

function automatic logic [5:0] prg_ref(input logic [15:0] a, input logic [4:0] bank8,
                                       input logic [5:0] bankc, input logic [5:0] mask);
    logic [5:0] bank;
    if (!a[15])
        bank = '0;                        // below $8000
    else if (!a[14])
        bank = {bank8, a[13]};            // 16 KB window
    else if (!a[13])
        bank = bankc;
    else
        bank = vrc6_map_pkg::prg_bank_fixed;
    return bank & mask;
endfunction

function automatic logic [8:0] chr_ref(input logic [13:0] a, input logic [7:0] bank,
                                       input logic [1:0] mirror, input logic [6:0] mask);
    logic a10;
    if (!a[13])
        a10 = bank[0];
    else if (mirror[1])
        a10 = mirror[0];                  // single screen
    else
        a10 = mirror[0] ? a[11] : a[10];
    return {{1'b0, bank[7:2]} & mask, bank[1], a10};
endfunction

// memory enables as {nesprg_oe, prgram_oe, wram_oe, wram_we, chrram_oe, chrram_we}
function automatic logic [5:0] mem_en_ref(input logic [15:0] a, input logic [13:0] ca,
                                          input logic we, input logic m2n,
                                          input logic rd, input logic wr,
                                          input logic boot, input logic chrram);
    logic in_wram;
    logic in_rom;
    logic in_pat;
    logic [5:0] en;
    in_wram = (a >= 16'h6000) && (a <= 16'h7fff);
    in_rom  = (a >= 16'h8000);
    in_pat  = (ca < 14'h2000);            // pattern tables only
    en[3] = m2n && !we && in_wram;
    en[2] = m2n && we && in_wram;
    en[4] = m2n && !we && in_rom && !boot;
    en[5] = en[4] || en[3];
    en[1] = rd && in_pat;
    en[0] = wr && in_pat && chrram;
    return en;
endfunction

// edges from the $F001 write to irq in cycle mode
function automatic int irq_edges(input logic [7:0] latch);
    return 256 - int'(latch);
endfunction

function automatic logic [5:0] mix_ref(input logic [3:0] v1, input logic [3:0] v2,
                                       input logic [4:0] saw);
    return 6'(int'(v1) + int'(v2) + int'(saw));
endfunction

// steps out of n where a 16 step sequencer sits at or below duty d
function automatic int duty_high_count(input logic [2:0] d, input int n);
    int i;
    int high;
    high = 0;
    for (i = 0; i < n; i++) begin
        if ((i % 16) <= int'(d))
            high++;
    end
    return high;
endfunction

// level after k accumulator steps, every seventh step clears
function automatic logic [4:0] saw_ref(input logic [5:0] rate, input int k);
    logic [7:0] acc;
    int s;
    acc = '0;
    for (s = 1; s <= k; s++) begin
        if (s % 7 == 0)
            acc = '0;
        else
            acc = acc + {2'b00, rate};    // wraps at 8 bits
    end
    return acc[7:3];
endfunction

`endif

//--- sim/vrc6_tb.sv
// VRC6 mapper testbench
// random banking sweeps, cycle mode IRQ timing and sound channel checks
// against the reference model in vrc6_tb_ref.svh
`timescale 1ns/1ps

module vrc6_tb;

    localparam int sweep_len     = 48;
    localparam int map_cycles    = 2 * (2 * 12 + 4 + sweep_len + 2);
    localparam int irq_cycles    = 2 * 4 + 300;
    localparam int snd_cycles    = 16 + 20 + 8 + 162 + 8 + 2 + 13 * 8;
    localparam int margin_cycles = 200;
    localparam int limit_cycles  = 8 + map_cycles + irq_cycles + snd_cycles + margin_cycles;

    logic clk20;
    logic reset;
    logic ce;
    logic nesprg_we;
    logic neschr_rd;
    logic neschr_wr;
    vrc6_map_pkg::cpu_addr_t prgain;
    vrc6_map_pkg::chr_addr_t chrain;
    vrc6_map_pkg::cpu_data_t nesprgdin;
    logic m2_n;
    logic cfg_boot;
    logic cfg_chrram;
    logic mapper26;
    vrc6_map_pkg::prg_bank_t cfg_prgmask;
    logic [6:0] cfg_chrmask;

    logic nesprg_oe;
    logic chrram_we;
    logic chrram_oe;
    logic wram_oe;
    logic wram_we;
    logic prgram_oe;
    logic ciram_ce;
    logic irq;
    vrc6_map_pkg::prg_bank_t ramprgaout;
    vrc6_map_pkg::chr_bank_t ramchraout;
    vrc6_snd_pkg::snd_level_t snd_level;

    logic [5:0] mem_en;      // nesprg_oe, prgram_oe, wram_oe, wram_we, chrram_oe, chrram_we

    // shadow of the bank registers
    logic [4:0] m_prg8;
    logic [5:0] m_prgc;
    logic [7:0] m_chr [8];
    logic [1:0] m_mirror;

    logic chk_map = 1'b0;
    logic chk_snd = 1'b0;
    vrc6_map_pkg::prg_bank_t exp_prg;
    vrc6_map_pkg::chr_bank_t exp_chr;
    logic exp_ciram;
    logic [5:0] exp_en;
    vrc6_snd_pkg::snd_level_t exp_snd;

    int map_errors = 0;
    int irq_errors = 0;
    int snd_errors = 0;

    logic [31:0] lfsr_state = 32'h3459_47e1;

    `include "vrc6_tb_ref.svh"

    vrc6_mapper dut_i (
        .clk20 (clk20), .reset (reset), .ce (ce), .nesprg_we (nesprg_we),
        .neschr_rd (neschr_rd), .neschr_wr (neschr_wr), .prgain (prgain), .chrain (chrain),
        .nesprgdin (nesprgdin), .m2_n (m2_n), .cfg_boot (cfg_boot), .cfg_chrram (cfg_chrram),
        .mapper26 (mapper26), .cfg_prgmask (cfg_prgmask), .cfg_chrmask (cfg_chrmask),
        .nesprg_oe (nesprg_oe), .chrram_we (chrram_we), .chrram_oe (chrram_oe),
        .wram_oe (wram_oe), .wram_we (wram_we), .prgram_oe (prgram_oe), .ciram_ce (ciram_ce),
        .irq (irq), .ramprgaout (ramprgaout), .ramchraout (ramchraout), .snd_level (snd_level)
    );

    assign mem_en = {nesprg_oe, prgram_oe, wram_oe, wram_we, chrram_oe, chrram_we};

    initial begin
        clk20 = 1'b0;
        forever #5 clk20 = ~clk20;
    end

    // inputs move on the falling edge, so the rising edge sees settled values
    always @(posedge clk20) begin
        if (chk_map) begin
            assert (ramprgaout == exp_prg && ramchraout == exp_chr && ciram_ce == exp_ciram)
            else begin
                map_errors++;
                $display("error at %0t: map %h/%h gave %h %h %b, expected %h %h %b",
                         $time, prgain, chrain, ramprgaout, ramchraout, ciram_ce,
                         exp_prg, exp_chr, exp_ciram);
            end
            assert (mem_en == exp_en) else begin
                map_errors++;
                $display("error at %0t: map %h/%h gave enables %b, expected %b",
                         $time, prgain, chrain, mem_en, exp_en);
            end
        end
        if (chk_snd) begin
            assert (snd_level == exp_snd) else begin
                snd_errors++;
                $display("error at %0t: snd_level %0d, expected %0d", $time, snd_level, exp_snd);
            end
        end
    end

    initial begin
        #(limit_cycles * 10);
        $display("watchdog expired, the tests did not finish within %0d cycles", limit_cycles);
        $display("Testbench failed");
        $finish;
    end

    // one CPU write, strobe high across a single rising edge
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk20);
        prgain = addr;
        nesprgdin = data;
        nesprg_we = 1'b1;
        @(negedge clk20);
        nesprg_we = 1'b0;
    endtask

    task automatic map_round(input logic m26);
        logic [7:0] v;
        int i;
        mapper26 = m26;
        cfg_prgmask = 6'(rand_bits(6));
        cfg_chrmask = 7'(rand_bits(7));
        cfg_boot = 1'(rand_bits(1));
        cfg_chrram = 1'(rand_bits(1));
        v = 8'(rand_bits(8));
        bus_write(16'h8000, v);
        m_prg8 = v[4:0];
        v = 8'(rand_bits(8));
        bus_write(16'hC000, v);
        m_prgc = v[5:0];
        for (i = 0; i < 8; i++) begin
            v = 8'(rand_bits(8));
            bus_write(reg_addr(i < 4 ? 16'hD000 : 16'hE000, 2'(i), m26), v);
            m_chr[i] = v;
        end
        v = 8'(rand_bits(8));
        bus_write(16'hB003, v);
        m_mirror = v[3:2];
        ce = 1'b0;                                  // this write must be ignored
        bus_write(16'h8000, {3'b000, ~m_prg8});
        ce = 1'b1;
        for (i = 0; i < sweep_len; i++) begin
            @(negedge clk20);
            prgain = 16'(rand_bits(16));
            chrain = 14'(rand_bits(14));
            m2_n = 1'(rand_bits(1));
            neschr_rd = 1'(rand_bits(1));
            neschr_wr = 1'(rand_bits(1));
            nesprg_we = 1'(rand_bits(1)) & ~prgain[15];   // no register below $8000
            exp_prg = prg_ref(prgain, m_prg8, m_prgc, cfg_prgmask);
            exp_chr = chr_ref(chrain, m_chr[chrain[12:10]], m_mirror, cfg_chrmask);
            exp_ciram = chrain[13];
            exp_en = mem_en_ref(prgain, chrain, nesprg_we, m2_n, neschr_rd, neschr_wr,
                                cfg_boot, cfg_chrram);
            chk_map = 1'b1;
        end
        @(negedge clk20);
        chk_map = 1'b0;
        nesprg_we = 1'b0;
    endtask

    task automatic irq_test();
        logic [7:0] latch;
        int k;
        latch = 8'(rand_bits(8));
        bus_write(16'hF000, latch);
        bus_write(16'hF001, 8'h06);                 // cycle mode, enable, A clear
        k = 0;
        while (!irq && k < 300) begin
            @(negedge clk20);
            k++;
        end
        assert (irq && k == irq_edges(latch)) else begin
            irq_errors++;
            $display("error at %0t: irq %b after %0d edges, expected rise at %0d (latch %0d)",
                     $time, irq, k, irq_edges(latch), latch);
        end
        bus_write(16'hF002, 8'h00);
        assert (!irq) else begin
            irq_errors++;
            $display("error at %0t: irq still high after the $F002 acknowledge", $time);
        end
    endtask

    task automatic mix_test();
        logic [3:0] v1;
        logic [3:0] v2;
        v1 = 4'(rand_bits(4));
        v2 = 4'(rand_bits(4));
        bus_write(16'hB002, 8'h00);                 // sawtooth off
        bus_write(16'h9000, {4'b1000, v1});         // digitizer mode
        bus_write(16'h9001, 8'h00);
        bus_write(16'h9002, 8'h80);
        bus_write(16'hA000, {4'b1000, v2});
        bus_write(16'hA001, 8'h00);
        bus_write(16'hA002, 8'h80);
        @(negedge clk20);                           // one edge for the mixer register
        exp_snd = mix_ref(v1, v2, 5'd0);
        chk_snd = 1'b1;
        repeat (8) @(negedge clk20);
        chk_snd = 1'b0;
        bus_write(16'h9002, 8'h00);
        @(negedge clk20);
        exp_snd = mix_ref(4'd0, v2, 5'd0);
        chk_snd = 1'b1;
        repeat (8) @(negedge clk20);
        chk_snd = 1'b0;
    endtask

    task automatic duty_test();
        logic [2:0] d;
        logic [3:0] v;
        int high;
        int other;
        d = 3'(rand_bits(3));
        v = {1'b1, 3'(rand_bits(3))};               // never zero
        high = 0;
        other = 0;
        bus_write(16'hA002, 8'h00);
        bus_write(16'h9000, {1'b0, d, v});
        bus_write(16'h9001, 8'h00);                 // period 0, one step per edge
        bus_write(16'h9002, 8'h80);
        @(negedge clk20);
        repeat (160) begin
            @(negedge clk20);
            if (snd_level == {2'b00, v})
                high++;
            else if (snd_level != '0)
                other++;
        end
        assert (high == duty_high_count(d, 160) && other == 0) else begin
            snd_errors++;
            $display("error at %0t: duty %0d gave %0d high and %0d stray, expected %0d high",
                     $time, d, high, other, duty_high_count(d, 160));
        end
    endtask

    task automatic saw_test();
        logic [5:0] rate;
        logic [1:0] f;
        logic [4:0] exp_saw;
        int period;
        int n;
        int k;
        rate = 6'(rand_bits(6));
        f = 2'(rand_bits(2));
        period = 2 * int'(f) + 2;                   // edges between accumulator steps
        bus_write(16'h9002, 8'h00);
        bus_write(16'hB000, {2'b00, rate});
        bus_write(16'hB001, {6'b000000, f});
        bus_write(16'hB002, 8'h80);
        n = 0;
        for (k = 1; k <= 14; k++) begin
            while (n < 2 + (k - 1) * period) begin
                @(negedge clk20);
                n++;
            end
            exp_saw = saw_ref(rate, k);
            assert (snd_level == {1'b0, exp_saw} && (k % 7 != 0 || snd_level == '0)) else begin
                snd_errors++;
                $display("error at %0t: saw step %0d rate %0d gave %0d, expected %0d",
                         $time, k, rate, snd_level, exp_saw);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        ce = 1'b1;
        nesprg_we = 1'b0;
        neschr_rd = 1'b0;
        neschr_wr = 1'b0;
        prgain = '0;
        chrain = '0;
        nesprgdin = '0;
        m2_n = 1'b1;
        cfg_boot = 1'b0;
        cfg_chrram = 1'b1;
        mapper26 = 1'b0;
        cfg_prgmask = '1;
        cfg_chrmask = '1;
        repeat (5) @(posedge clk20);
        @(negedge clk20);
        reset = 1'b0;
        @(negedge clk20);
        assert (!irq) else begin
            irq_errors++;
            $display("error at %0t: irq %b after reset, expected 0", $time, irq);
        end
        assert (snd_level == '0) else begin
            snd_errors++;
            $display("error at %0t: snd_level %0d after reset, expected 0", $time, snd_level);
        end
        map_round(1'b0);
        map_round(1'b1);
        mapper26 = 1'b0;
        irq_test();
        mix_test();
        duty_test();
        saw_test();
        $display("error counts: banking %0d, irq %0d, sound %0d",
                 map_errors, irq_errors, snd_errors);
        if (map_errors + irq_errors + snd_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog/vrc6_mapper.sv
// VRC6 mapper top level
// ties together register decode and banking, the IRQ counter and the sound block
`timescale 1ns/1ps

module vrc6_mapper (
    input  logic                        clk20,
    input  logic                        reset,
    input  logic                        ce,
    input  logic                        nesprg_we,
    input  logic                        neschr_rd,
    input  logic                        neschr_wr,
    input  vrc6_map_pkg::cpu_addr_t     prgain,
    input  vrc6_map_pkg::chr_addr_t     chrain,
    input  vrc6_map_pkg::cpu_data_t     nesprgdin,
    input  logic                        m2_n,
    input  logic                        cfg_boot,
    input  logic                        cfg_chrram,
    input  logic                        mapper26,     // A0/A1 swapped variant
    input  vrc6_map_pkg::prg_bank_t     cfg_prgmask,
    input  logic [6:0]                  cfg_chrmask,
    output logic                        nesprg_oe,
    output logic                        chrram_we,
    output logic                        chrram_oe,
    output logic                        wram_oe,
    output logic                        wram_we,
    output logic                        prgram_oe,
    output logic                        ciram_ce,
    output logic                        irq,
    output vrc6_map_pkg::prg_bank_t     ramprgaout,
    output vrc6_map_pkg::chr_bank_t     ramchraout,
    output vrc6_snd_pkg::snd_level_t    snd_level
);

    logic irq_latch_we;
    logic irq_ctrl_we;
    logic irq_ack_we;
    logic snd_we;
    vrc6_map_pkg::snd_sel_t snd_sel;

    vrc6_cpu_regs regs_i (
        .clk20        (clk20),
        .reset        (reset),
        .ce           (ce),
        .nesprg_we    (nesprg_we),
        .neschr_rd    (neschr_rd),
        .neschr_wr    (neschr_wr),
        .prgain       (prgain),
        .chrain       (chrain),
        .nesprgdin    (nesprgdin),
        .m2_n         (m2_n),
        .cfg_boot     (cfg_boot),
        .cfg_chrram   (cfg_chrram),
        .mapper26     (mapper26),
        .cfg_prgmask  (cfg_prgmask),
        .cfg_chrmask  (cfg_chrmask),
        .ramprgaout   (ramprgaout),
        .ramchraout   (ramchraout),
        .ciram_ce     (ciram_ce),
        .chrram_we    (chrram_we),
        .chrram_oe    (chrram_oe),
        .wram_oe      (wram_oe),
        .wram_we      (wram_we),
        .prgram_oe    (prgram_oe),
        .nesprg_oe    (nesprg_oe),
        .irq_latch_we (irq_latch_we),
        .irq_ctrl_we  (irq_ctrl_we),
        .irq_ack_we   (irq_ack_we),
        .snd_we       (snd_we),
        .snd_sel      (snd_sel)
    );

    vrc6_irq irq_i (
        .clk20        (clk20),
        .reset        (reset),
        .ce           (ce),
        .irq_latch_we (irq_latch_we),
        .irq_ctrl_we  (irq_ctrl_we),
        .irq_ack_we   (irq_ack_we),
        .nesprgdin    (nesprgdin),
        .irq          (irq)
    );

    vrc6_sound sound_i (
        .clk20     (clk20),
        .reset     (reset),
        .ce        (ce),
        .snd_we    (snd_we),
        .snd_sel   (snd_sel),
        .nesprgdin (nesprgdin),
        .snd_level (snd_level)
    );

endmodule

//--- verilog/vrc6_cpu_regs.sv
// VRC6 CPU register decode and banking
// holds PRG/CHR bank and mirroring registers, translates bus addresses
// to RAM addresses and hands IRQ and sound writes on as one-cycle strobes
`timescale 1ns/1ps

module vrc6_cpu_regs (
    input  logic                     clk20,
    input  logic                     reset,
    input  logic                     ce,
    input  logic                     nesprg_we,
    input  logic                     neschr_rd,
    input  logic                     neschr_wr,
    input  vrc6_map_pkg::cpu_addr_t  prgain,
    input  vrc6_map_pkg::chr_addr_t  chrain,
    input  vrc6_map_pkg::cpu_data_t  nesprgdin,
    input  logic                     m2_n,
    input  logic                     cfg_boot,
    input  logic                     cfg_chrram,
    input  logic                     mapper26,
    input  vrc6_map_pkg::prg_bank_t  cfg_prgmask,
    input  logic [6:0]               cfg_chrmask,
    output vrc6_map_pkg::prg_bank_t  ramprgaout,
    output vrc6_map_pkg::chr_bank_t  ramchraout,
    output logic                     ciram_ce,
    output logic                     chrram_we,
    output logic                     chrram_oe,
    output logic                     wram_oe,
    output logic                     wram_we,
    output logic                     prgram_oe,
    output logic                     nesprg_oe,
    output logic                     irq_latch_we,
    output logic                     irq_ctrl_we,
    output logic                     irq_ack_we,
    output logic                     snd_we,
    output vrc6_map_pkg::snd_sel_t   snd_sel
);

    vrc6_map_pkg::cpu_addr_t ain;
    vrc6_map_pkg::prg_bank_t prg_bank_c;
    vrc6_map_pkg::prg_bank_t prg_bank;
    logic [5:0] reg_sel;
    logic       wr;
    logic [4:0] prg_bank8;           // 16 KB bank at $8000
    logic [7:0] chr_bank [8];
    logic [7:0] chr_sel;
    logic [1:0] mirror;
    logic       chr_a10;

    // mapper 26 boards cross A0 and A1 on the register select
    assign ain     = mapper26 ? {prgain[15:2], prgain[0], prgain[1]} : prgain;
    assign reg_sel = {ain[15:12], ain[1:0]};
    assign wr      = ce & nesprg_we;

    assign irq_latch_we = wr & (reg_sel == 6'b111100);  // F000
    assign irq_ctrl_we  = wr & (reg_sel == 6'b111101);  // F001
    assign irq_ack_we   = wr & (reg_sel == 6'b111110);  // F002

    // 9000-B002, B003 is the mirroring register
    assign snd_we  = wr & (ain[15:14] == 2'b10) & (ain[13:12] != 2'b00) & (ain[1:0] != 2'b11);
    assign snd_sel = {ain[13:12], ain[1:0]};

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            prg_bank8  <= '0;
            prg_bank_c <= '0;
            mirror     <= '0;
            chr_bank   <= '{default: '0};
        end else if (wr) begin
            case (reg_sel) inside
                6'b1000??: prg_bank8 <= nesprgdin[4:0];
                6'b1100??: prg_bank_c <= nesprgdin[5:0];
                6'b101111: mirror <= nesprgdin[3:2];
                6'b1101??: chr_bank[{1'b0, reg_sel[1:0]}] <= nesprgdin;  // D000-D003
                6'b1110??: chr_bank[{1'b1, reg_sel[1:0]}] <= nesprgdin;  // E000-E003
                default: ;
            endcase
        end
    end

    always_comb begin
        case (prgain[15:13])
            3'b100, 3'b101: prg_bank = {prg_bank8, prgain[13]};
            3'b110:         prg_bank = prg_bank_c;
            3'b111:         prg_bank = vrc6_map_pkg::prg_bank_fixed;
            default:        prg_bank = '0;   // below $8000
        endcase
    end

    assign ramprgaout = prg_bank & cfg_prgmask;

    assign chr_sel = chr_bank[chrain[12:10]];

    // nametable page select
    always_comb begin
        if (!chrain[13]) begin
            chr_a10 = chr_sel[0];
        end else begin
            case (mirror)
                2'd0:    chr_a10 = chrain[10];   // vertical
                2'd1:    chr_a10 = chrain[11];   // horizontal
                2'd2:    chr_a10 = 1'b0;
                default: chr_a10 = 1'b1;
            endcase
        end
    end

    assign ramchraout = {{1'b0, chr_sel[7:2]} & cfg_chrmask, chr_sel[1], chr_a10};
    assign ciram_ce   = chrain[13];

    assign chrram_we = neschr_wr & ~chrain[13] & cfg_chrram;
    assign chrram_oe = neschr_rd & ~chrain[13];
    assign wram_oe   = m2_n & ~nesprg_we & (prgain[15:13] == vrc6_map_pkg::wram_region);
    assign wram_we   = m2_n & nesprg_we & (prgain[15:13] == vrc6_map_pkg::wram_region);
    assign prgram_oe = ~cfg_boot & m2_n & ~nesprg_we & prgain[15];
    assign nesprg_oe = wram_oe | prgram_oe;

    // strobes fan out to the IRQ and sound blocks, which never see two at once
    assert property (@(posedge clk20) disable iff (reset)
        $onehot0({irq_latch_we, irq_ctrl_we, irq_ack_we, snd_we}));

endmodule

//--- verilog/vrc6_irq.sv
// VRC6 IRQ counter
// 8-bit up counter clocked per CPU cycle or per scanline via the prescaler,
// reloads from the latch on overflow and raises irq
`timescale 1ns/1ps

module vrc6_irq (
    input  logic                     clk20,
    input  logic                     reset,
    input  logic                     ce,
    input  logic                     irq_latch_we,
    input  logic                     irq_ctrl_we,
    input  logic                     irq_ack_we,
    input  vrc6_map_pkg::cpu_data_t  nesprgdin,
    output logic                     irq
);

    logic [7:0] latch;
    logic       mode;       // 1 = cycle mode
    logic       irq_en;
    logic       irq_a;      // enable after acknowledge
    logic [6:0] scaler;
    logic [1:0] line;
    logic [7:0] count;
    logic       step;
    logic       restart;

    assign step    = mode | (scaler == 7'd0);
    assign restart = irq_ctrl_we & nesprgdin[1];

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            latch  <= '0;
            mode   <= 1'b0;
            irq_a  <= 1'b0;
            scaler <= '0;
            line   <= '0;
            count  <= '0;
        end else begin
            if (irq_latch_we)
                latch <= nesprgdin;
            if (irq_ctrl_we) begin
                mode  <= nesprgdin[2];
                irq_a <= nesprgdin[0];
            end
            if (restart) begin
                scaler <= vrc6_snd_pkg::irq_scaler_long;
                line   <= '0;
                count  <= latch;
            end else if (ce && irq_en) begin
                if (scaler != 7'd0) begin
                    scaler <= scaler - 7'd1;
                end else begin
                    // 114, 114, 113 cycles per scanline
                    scaler <= line[1] ? vrc6_snd_pkg::irq_scaler_short
                                      : vrc6_snd_pkg::irq_scaler_long;
                    line   <= line[1] ? 2'd0 : line + 2'd1;
                end
                if (step) begin
                    if (count == 8'hff)
                        count <= latch;
                    else
                        count <= count + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            irq_en <= 1'b0;
            irq    <= 1'b0;
        end else begin
            if (irq_ctrl_we)
                irq_en <= nesprgdin[1];
            else if (irq_ack_we)
                irq_en <= irq_a;

            if (irq_ctrl_we || irq_ack_we)
                irq <= 1'b0;                 // any control write acknowledges
            else if (ce && irq_en && step && count == 8'hff)
                irq <= 1'b1;
        end
    end

    // enable and irq only change together on control writes
    assert property (@(posedge clk20) disable iff (reset) irq |-> irq_en);

endmodule

//--- verilog/vrc6_sound.sv
// VRC6 expansion sound
// register file for two pulse channels and the sawtooth, linear mix to 6 bits
`timescale 1ns/1ps

module vrc6_sound (
    input  logic                      clk20,
    input  logic                      reset,
    input  logic                      ce,
    input  logic                      snd_we,
    input  vrc6_map_pkg::snd_sel_t    snd_sel,
    input  vrc6_map_pkg::cpu_data_t   nesprgdin,
    output vrc6_snd_pkg::snd_level_t  snd_level
);

    logic [1:0]                  ch_idx;     // 0 pulse 1, 1 pulse 2, 2 saw
    logic [2:0]                  ch_en;
    logic [1:0]                  pl_mode;
    vrc6_snd_pkg::duty_t         pl_duty [2];
    vrc6_snd_pkg::vol_t          pl_vol [2];
    vrc6_snd_pkg::freq_t         freq [3];
    vrc6_snd_pkg::saw_rate_t     saw_rate;
    vrc6_snd_pkg::pulse_level_t  sq1_level;
    vrc6_snd_pkg::pulse_level_t  sq2_level;
    vrc6_snd_pkg::saw_level_t    saw_level;

    assign ch_idx = snd_sel[3:2] - 2'd1;

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset)
            ch_en <= '0;
        else if (snd_we && snd_sel[1:0] == 2'd2)
            ch_en[ch_idx] <= nesprgdin[7];
    end

    always_ff @(posedge clk20) begin
        if (snd_we) begin
            case (snd_sel[1:0])
                2'd0: begin
                    if (ch_idx == 2'd2)
                        saw_rate <= nesprgdin[5:0];
                    else
                        {pl_mode[ch_idx[0]], pl_duty[ch_idx[0]], pl_vol[ch_idx[0]]} <= nesprgdin;
                end
                2'd1:    freq[ch_idx][7:0] <= nesprgdin;
                2'd2:    freq[ch_idx][11:8] <= nesprgdin[3:0];
                default: ;
            endcase
        end
    end

    vrc6_pulse sq1_i (
        .clk20 (clk20), .reset (reset), .ce (ce), .en (ch_en[0]), .mode (pl_mode[0]),
        .duty (pl_duty[0]), .vol (pl_vol[0]), .freq (freq[0]), .level (sq1_level)
    );

    vrc6_pulse sq2_i (
        .clk20 (clk20), .reset (reset), .ce (ce), .en (ch_en[1]), .mode (pl_mode[1]),
        .duty (pl_duty[1]), .vol (pl_vol[1]), .freq (freq[1]), .level (sq2_level)
    );

    vrc6_saw saw_i (
        .clk20 (clk20), .reset (reset), .ce (ce), .en (ch_en[2]),
        .rate (saw_rate), .freq (freq[2]), .level (saw_level)
    );

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset)
            snd_level <= '0;
        else
            snd_level <= {2'b00, sq1_level} + {2'b00, sq2_level} + {1'b0, saw_level};
    end

    // full scale of all three channels together
    assert property (@(posedge clk20) disable iff (reset)
        snd_level <= vrc6_snd_pkg::snd_level_max);

endmodule

//--- verilog/vrc6_saw.sv
// VRC6 sawtooth channel
// accumulator adds the rate every other divider period, clears after 7 steps
`timescale 1ns/1ps

module vrc6_saw (
    input  logic                      clk20,
    input  logic                      reset,
    input  logic                      ce,
    input  logic                      en,
    input  vrc6_snd_pkg::saw_rate_t   rate,
    input  vrc6_snd_pkg::freq_t       freq,
    output vrc6_snd_pkg::saw_level_t  level
);

    logic [12:0] div;
    logic [2:0]  step;
    logic [7:0]  acc;

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            div  <= '0;
            step <= '0;
            acc  <= '0;
        end else if (ce && en) begin
            if (div != '0) begin
                div <= div - 13'd1;
            end else begin
                div <= {freq, 1'b1};         // twice the period plus one
                if (step == vrc6_snd_pkg::saw_steps - 3'd1) begin
                    step <= '0;
                    acc  <= '0;
                end else begin
                    step <= step + 3'd1;
                    acc  <= acc + {2'b00, rate};
                end
            end
        end
    end

    assign level = en ? acc[7:3] : '0;

endmodule

//--- verilog/vrc6_pulse.sv
// VRC6 pulse channel
// period divider, 16-step duty sequencer, digitizer mode forces the volume out
`timescale 1ns/1ps

module vrc6_pulse (
    input  logic                        clk20,
    input  logic                        reset,
    input  logic                        ce,
    input  logic                        en,
    input  logic                        mode,    // digitizer
    input  vrc6_snd_pkg::duty_t         duty,
    input  vrc6_snd_pkg::vol_t          vol,
    input  vrc6_snd_pkg::freq_t         freq,
    output vrc6_snd_pkg::pulse_level_t  level
);

    vrc6_snd_pkg::freq_t div;
    logic [3:0]          step;

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            div  <= '0;
            step <= '0;
        end else if (ce && en) begin
            if (div != '0) begin
                div <= div - 12'd1;
            end else begin
                div  <= freq;
                step <= step + 4'd1;
            end
        end
    end

    // high for duty+1 of 16 steps
    assign level = (en && (mode || step <= {1'b0, duty})) ? vol : '0;

endmodule

//--- verilog/vrc6_snd_pkg.sv
// VRC6 sound channel definitions
// levels, periods and rates of the pulse and sawtooth channels,
// plus the scanline prescaler constants of the IRQ counter
package vrc6_snd_pkg;

    typedef logic [11:0] freq_t;        // channel period
    typedef logic [3:0]  vol_t;
    typedef logic [5:0]  saw_rate_t;    // accumulator add per step
    typedef logic [2:0]  duty_t;

    // channel and mixer output levels
    typedef logic [3:0]  pulse_level_t;
    typedef logic [4:0]  saw_level_t;
    typedef logic [5:0]  snd_level_t;

    // 15 + 15 + 31
    localparam snd_level_t snd_level_max = 6'd61;

    // accumulator clears after this many steps
    localparam logic [2:0] saw_steps = 3'd7;

    // prescaler reload values, 341/3 CPU cycles per scanline on average
    localparam logic [6:0] irq_scaler_long  = 7'd113;
    localparam logic [6:0] irq_scaler_short = 7'd112;

endpackage

//--- verilog/vrc6_map_pkg.sv
// VRC6 bus decoding and bank translation definitions
// widths of the CPU and PPU buses and the banked RAM address fields
package vrc6_map_pkg;

    // CPU side
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // PPU side
    typedef logic [13:0] chr_addr_t;

    // banked RAM address fields
    typedef logic [5:0]  prg_bank_t;   // RAM address 18..13
    typedef logic [8:0]  chr_bank_t;   // RAM address 18..10

    // sound register select, channel in [3:2] and register in [1:0]
    // channel 1 is pulse 1 ($9xxx), 2 is pulse 2 ($Axxx), 3 is the saw ($Bxxx)
    typedef logic [3:0]  snd_sel_t;

    // last 8 KB of PRG ROM is hardwired at $E000
    localparam prg_bank_t prg_bank_fixed = 6'b111111;

    // A15..A13 of the work RAM window at $6000
    localparam logic [2:0] wram_region = 3'b011;

endpackage
